// File: include/uart_params.svh
// UART sizing macros: FIFO depth, divider width, reset divider, register offsets
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

`define UART_FIFO_DEPTH  4                      // Entries per FIFO
`define UART_DIV_WIDTH   16                     // Baud divider bits
`define UART_DIV_DEFAULT 16                     // Cycles per bit after reset

// Byte offsets inside the peripheral window
`define UART_REG_TXDATA  4'h0
`define UART_REG_RXDATA  4'h4
`define UART_REG_STATUS  4'h8
`define UART_REG_BAUD    4'hC

`endif

// File: hw/ahb_pkg.sv
// AHB-Lite transfer type, response type and register offset type
package ahb_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,                         // No transfer
        BUSY   = 2'b01,                         // Master inserts idle beat
        NONSEQ = 2'b10,                         // Single or first beat
        SEQ    = 2'b11                          // Following beat of a burst
    } ahb_htrans_t;

    typedef enum logic [1:0] {
        OKAY  = 2'b00,                          // Only response the slave drives
        ERROR = 2'b01
    } ahb_hresp_t;

    // Word offset from the low address bits, selects one of four registers
    typedef logic [3:0] reg_offset_t;

endpackage : ahb_pkg

// File: hw/uart_pkg.sv
// UART payload types: data byte, received frame and status word fields
package uart_pkg;

    typedef logic [7:0] uart_byte_t;            // Transmit FIFO entry

    // Receive FIFO entry, frame error sits above the byte on RXDATA
    typedef struct packed {
        logic       frame_err;                  // Stop bit read low
        uart_byte_t data;                       // Received byte
    } rx_frame_t;

    // Status register, field order gives the bit positions
    typedef struct packed {
        logic tx_busy;                          // Bit 4, serializer shifting
        logic overrun;                          // Bit 3, sticky, cleared by write
        logic rx_frame_err;                     // Bit 2, head entry frame error
        logic rx_empty;                         // Bit 1, nothing to read
        logic tx_full;                          // Bit 0, no room for TXDATA
    } uart_status_t;

endpackage : uart_pkg

// File: hw/uart_fifo.sv
// Synchronous circular FIFO with a type-parameter payload
`include "uart_params.svh"

module uart_fifo
    import uart_pkg::*;
#(
    parameter type payload_t = uart_byte_t
) (
    input  logic     hclk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int DEPTH = `UART_FIFO_DEPTH;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;                     // Entries held
    logic            do_push;
    logic            do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign full     = (count == CW'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];              // Head always visible

    always_ff @(posedge hclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge hclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule : uart_fifo

// File: hw/uart_tx.sv
// UART serializer: start bit, eight data bits LSB first, stop bit
`include "uart_params.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic                       hclk,
    input  logic                       reset,
    input  logic [`UART_DIV_WIDTH-1:0] divider,
    input  logic                       tx_valid,
    input  uart_byte_t                 tx_byte,
    output logic                       tx_ready,
    output logic                       busy,
    output logic                       uart_tx
);

    logic [8:0]                 shreg;          // Data bits then stop bit
    logic [3:0]                 bit_cnt;        // Bits finished in this frame
    logic [`UART_DIV_WIDTH-1:0] baud_cnt;
    logic                       bit_end;

    assign tx_ready = !busy;                    // Accept only when idle
    assign bit_end  = (baud_cnt == divider - 1'b1);

    always_ff @(posedge hclk) begin
        if (reset) begin
            busy     <= 1'b0;
            uart_tx  <= 1'b1;                   // Line idles high
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (!busy) begin
            if (tx_valid) begin
                busy     <= 1'b1;
                uart_tx  <= 1'b0;               // Start bit next cycle on
                bit_cnt  <= '0;
                baud_cnt <= '0;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;                   // Stop bit done, line stays high
            end else begin
                uart_tx <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge hclk) begin
        if (!busy && tx_valid) begin
            shreg <= {1'b1, tx_byte};           // Stop bit above the byte
        end else if (busy && bit_end) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule : uart_tx

// File: hw/uart_rx.sv
// UART deserializer: synchronizer, start detect, mid-bit sampling, stop-bit check
`include "uart_params.svh"

module uart_rx
    import uart_pkg::*;
(
    input  logic                       hclk,
    input  logic                       reset,
    input  logic [`UART_DIV_WIDTH-1:0] divider,
    input  logic                       uart_rx,
    output logic                       rx_valid,
    output rx_frame_t                  rx_frame
);

    typedef enum logic [1:0] {
        RX_IDLE,                                // Waiting for a falling edge
        RX_START,                               // Confirm start at half bit
        RX_DATA,                                // Eight samples at bit centers
        RX_STOP                                 // Stop-bit sample
    } rx_state_t;

    rx_state_t                  state;
    logic                       rx_meta;        // First synchronizer flop
    logic                       rx_sync;
    logic                       rx_prev;        // For edge detection
    logic [2:0]                 bit_cnt;
    logic [`UART_DIV_WIDTH-1:0] baud_cnt;
    uart_byte_t                 shreg;
    logic                       bit_end;

    assign bit_end = (baud_cnt == divider - 1'b1);

    always_ff @(posedge hclk) begin
        if (reset) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_prev  <= 1'b1;
            state    <= RX_IDLE;
            rx_valid <= 1'b0;
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else begin
            rx_meta  <= uart_rx;
            rx_sync  <= rx_meta;
            rx_prev  <= rx_sync;
            rx_valid <= 1'b0;                   // One-cycle pulse
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (baud_cnt == (divider >> 1)) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA;  // Glitch goes back
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        rx_valid <= 1'b1;       // Middle of the stop bit
                        state    <= RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge hclk) begin
        if (state == RX_DATA && bit_end) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
        if (state == RX_STOP && bit_end) begin
            rx_frame.data      <= shreg;
            rx_frame.frame_err <= !rx_sync;     // Stop bit read low
        end
    end

endmodule : uart_rx

// File: hw/ahb_uart_bridge.sv
// AHB-Lite slave bridge: address-phase capture and one-cycle data-phase strobes
module ahb_uart_bridge
    import ahb_pkg::*;
(
    input  logic        hclk,
    input  logic        reset,
    input  logic [31:0] haddr,
    input  logic        hwrite,
    input  ahb_htrans_t htrans,
    input  logic        hsel,
    output logic        hready,
    output ahb_hresp_t  hresp,
    output logic        wr_en,
    output logic        rd_en,
    output reg_offset_t reg_addr
);

    logic xfer;                                 // Valid address phase this cycle

    assign xfer   = hsel && (htrans == NONSEQ || htrans == SEQ);
    assign hready = 1'b1;                       // Zero wait states
    assign hresp  = OKAY;

    // Direction becomes a strobe in the data phase
    always_ff @(posedge hclk) begin
        if (reset) begin
            wr_en <= 1'b0;
            rd_en <= 1'b0;
        end else begin
            wr_en <= xfer && hwrite;
            rd_en <= xfer && !hwrite;
        end
    end

    always_ff @(posedge hclk) begin
        if (xfer) begin
            reg_addr <= reg_offset_t'(haddr[3:0]);  // Word offset only
        end
    end

endmodule : ahb_uart_bridge

// File: hw/uart_regs.sv
// UART register block: offset decode, status, baud divider, overrun, FIFO strobes
`include "uart_params.svh"

module uart_regs
    import ahb_pkg::*;
    import uart_pkg::*;
(
    input  logic                       hclk,
    input  logic                       reset,
    input  logic                       wr_en,
    input  logic                       rd_en,
    input  reg_offset_t                reg_addr,
    input  logic [31:0]                wr_data,
    input  logic                       tx_full,
    input  logic                       rx_empty,
    input  rx_frame_t                  rx_head,
    input  logic                       rx_valid,
    input  logic                       rx_full,
    input  logic                       tx_busy,
    output logic [31:0]                rd_data,
    output logic                       tx_push,
    output uart_byte_t                 tx_push_byte,
    output logic                       rx_pop,
    output logic [`UART_DIV_WIDTH-1:0] divider
);

    logic         sel_tx;                       // Decoded offsets
    logic         sel_rx;
    logic         sel_status;
    logic         sel_baud;
    logic         overrun;
    uart_status_t status;

    assign sel_tx     = (reg_addr == `UART_REG_TXDATA);
    assign sel_rx     = (reg_addr == `UART_REG_RXDATA);
    assign sel_status = (reg_addr == `UART_REG_STATUS);
    assign sel_baud   = (reg_addr == `UART_REG_BAUD);

    assign tx_push      = wr_en && sel_tx && !tx_full;   // Drop write when full
    assign tx_push_byte = wr_data[7:0];
    assign rx_pop       = rd_en && sel_rx && !rx_empty;  // Empty read pops nothing

    always_ff @(posedge hclk) begin
        if (reset) begin
            divider <= `UART_DIV_WIDTH'(`UART_DIV_DEFAULT);
        end else if (wr_en && sel_baud) begin
            divider <= wr_data[`UART_DIV_WIDTH-1:0];
        end
    end

    // Set beats clear when a byte is lost in the same cycle
    always_ff @(posedge hclk) begin
        if (reset) begin
            overrun <= 1'b0;
        end else if (rx_valid && rx_full) begin
            overrun <= 1'b1;
        end else if (wr_en && sel_status) begin
            overrun <= 1'b0;                    // Any value clears
        end
    end

    always_comb begin
        status.tx_busy      = tx_busy;
        status.overrun      = overrun;
        status.rx_frame_err = !rx_empty && rx_head.frame_err;  // Head may be stale
        status.rx_empty     = rx_empty;
        status.tx_full      = tx_full;
    end

    // Read mux, valid in the data phase since reg_addr is registered
    always_comb begin
        rd_data = '0;
        if (sel_rx && !rx_empty) begin
            rd_data = 32'(rx_head);             // Frame error lands on bit 8
        end else if (sel_status) begin
            rd_data = 32'(status);
        end else if (sel_baud) begin
            rd_data = 32'(divider);
        end
    end

endmodule : uart_regs

// File: hw/ahb_uart.sv
// Top level of the AHB-Lite UART: bridge, registers, two FIFOs, serializer, deserializer
`include "uart_params.svh"

module ahb_uart
    import ahb_pkg::*;
    import uart_pkg::*;
(
    input  logic        hclk,
    input  logic        reset,
    input  logic [31:0] haddr,
    input  logic [31:0] hwdata,
    output logic [31:0] hrdata,
    input  logic        hwrite,
    input  ahb_htrans_t htrans,
    input  logic [2:0]  hsize,                  // Every access treated as a word
    input  logic [2:0]  hburst,                 // Only single beats are served
    input  logic        hsel,
    output logic        hready,
    output ahb_hresp_t  hresp,
    output logic        uart_tx,
    input  logic        uart_rx
);

    logic                       wr_en;          // Data-phase write strobe
    logic                       rd_en;          // Data-phase read strobe
    reg_offset_t                reg_addr;
    logic [`UART_DIV_WIDTH-1:0] divider;

    logic       tx_push;
    uart_byte_t tx_push_byte;
    uart_byte_t tx_byte;                        // FIFO head to serializer
    logic       tx_full;
    logic       tx_empty;
    logic       tx_valid;
    logic       tx_ready;
    logic       tx_busy;

    logic      rx_valid;                        // Frame done, one cycle
    rx_frame_t rx_frame;
    logic      rx_push;
    logic      rx_pop;
    rx_frame_t rx_head;
    logic      rx_full;
    logic      rx_empty;

    assign tx_valid = !tx_empty;                // Anything queued is offered
    assign rx_push  = rx_valid && !rx_full;     // Frame lost when full

    ahb_uart_bridge bridge_i (
        .hclk     (hclk),
        .reset    (reset),
        .haddr    (haddr),
        .hwrite   (hwrite),
        .htrans   (htrans),
        .hsel     (hsel),
        .hready   (hready),
        .hresp    (hresp),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .reg_addr (reg_addr)
    );

    uart_regs regs_i (
        .hclk         (hclk),
        .reset        (reset),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .reg_addr     (reg_addr),
        .wr_data      (hwdata),
        .tx_full      (tx_full),
        .rx_empty     (rx_empty),
        .rx_head      (rx_head),
        .rx_valid     (rx_valid),
        .rx_full      (rx_full),
        .tx_busy      (tx_busy),
        .rd_data      (hrdata),
        .tx_push      (tx_push),
        .tx_push_byte (tx_push_byte),
        .rx_pop       (rx_pop),
        .divider      (divider)
    );

    uart_fifo #(.payload_t(uart_byte_t)) tx_fifo_i (
        .hclk      (hclk),
        .reset     (reset),
        .push      (tx_push),
        .push_data (tx_push_byte),
        .pop       (tx_valid && tx_ready),      // Handshake moves the head
        .pop_data  (tx_byte),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    uart_fifo #(.payload_t(rx_frame_t)) rx_fifo_i (
        .hclk      (hclk),
        .reset     (reset),
        .push      (rx_push),
        .push_data (rx_frame),
        .pop       (rx_pop),
        .pop_data  (rx_head),
        .full      (rx_full),
        .empty     (rx_empty)
    );

    uart_tx tx_i (
        .hclk     (hclk),
        .reset    (reset),
        .divider  (divider),
        .tx_valid (tx_valid),
        .tx_byte  (tx_byte),
        .tx_ready (tx_ready),
        .busy     (tx_busy),
        .uart_tx  (uart_tx)
    );

    uart_rx rx_i (
        .hclk     (hclk),
        .reset    (reset),
        .divider  (divider),
        .uart_rx  (uart_rx),
        .rx_valid (rx_valid),
        .rx_frame (rx_frame)
    );

endmodule : ahb_uart

// File: bench/ahb_uart_props.sv
// Bound assertions for the AHB-Lite UART: OKAY response, idle line level, no push into full FIFO
module ahb_uart_props
    import ahb_pkg::*;
(
    input logic       hclk,
    input logic       reset,
    input ahb_hresp_t hresp,
    input logic       uart_tx,
    input logic       tx_busy,
    input logic       tx_push,
    input logic       tx_full,
    input logic       rx_push,
    input logic       rx_full
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned assert_fails = 0;              // Seen by the testbench at the end

    hresp_okay: assert property (@(posedge hclk) disable iff (reset) hresp == OKAY)
        else begin
            assert_fails++;
            $error("AHB response other than OKAY");
        end

    // Line must rest high between frames
    idle_high: assert property (@(posedge hclk) disable iff (reset) !tx_busy |-> uart_tx)
        else begin
            assert_fails++;
            $error("Serial output low while transmitter idle");
        end

    tx_no_overfill: assert property (@(posedge hclk) disable iff (reset) !(tx_push && tx_full))
        else begin
            assert_fails++;
            $error("Transmit FIFO pushed while full");
        end

    rx_no_overfill: assert property (@(posedge hclk) disable iff (reset) !(rx_push && rx_full))
        else begin
            assert_fails++;
            $error("Receive FIFO pushed while full");
        end

endmodule : ahb_uart_props

bind ahb_uart ahb_uart_props props_i (
    .hclk    (hclk),
    .reset   (reset),
    .hresp   (hresp),
    .uart_tx (uart_tx),
    .tx_busy (tx_busy),
    .tx_push (tx_push),
    .tx_full (tx_full),
    .rx_push (rx_push),
    .rx_full (rx_full)
);

// File: bench/ahb_uart_tb.sv
// Testbench for the AHB-Lite UART: clock, reset, bus and serial tasks, directed tests, compares
`include "uart_params.svh"

module ahb_uart_tb
    import ahb_pkg::*;
    import uart_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic                       hclk;
    logic                       reset;
    logic [31:0]                haddr;
    logic [31:0]                hwdata;
    logic [31:0]                hrdata;
    logic                       hwrite;
    ahb_htrans_t                htrans;
    logic [2:0]                 hsize;
    logic [2:0]                 hburst;
    logic                       hsel;
    logic                       hready;
    ahb_hresp_t                 hresp;
    logic                       uart_tx;
    logic                       uart_rx;
    logic                       use_driver;     // Serial driver owns uart_rx
    logic                       drv_line;
    logic [`UART_DIV_WIDTH-1:0] cur_div;        // Cycles per bit in the DUT
    string                      test_name;

    assign uart_rx = use_driver ? drv_line : uart_tx;  // Loopback unless driven

    ahb_uart dut_i (
        .hclk   (hclk),
        .reset  (reset),
        .haddr  (haddr),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hwrite (hwrite),
        .htrans (htrans),
        .hsize  (hsize),
        .hburst (hburst),
        .hsel   (hsel),
        .hready (hready),
        .hresp  (hresp),
        .uart_tx(uart_tx),
        .uart_rx(uart_rx)
    );

    initial begin
        hclk = 1'b0;
        forever #20 hclk = ~hclk;               // 40 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_word(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %h, actual %h", test_name, exp, act));
        end
    endtask

    task automatic check_byte(input uart_byte_t exp, input uart_byte_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %h, actual %h", test_name, exp, act));
        end
    endtask

    task automatic check_status(input uart_status_t exp, input uart_status_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %b, actual %b", test_name, exp, act));
        end
    endtask

    task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge hclk);
        haddr  <= addr;                         // Address phase
        hwrite <= 1'b1;
        htrans <= NONSEQ;
        hsel   <= 1'b1;
        @(posedge hclk);
        htrans <= IDLE;
        hsel   <= 1'b0;
        hwdata <= data;                         // Data phase
    endtask

    task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge hclk);
        haddr  <= addr;
        hwrite <= 1'b0;
        htrans <= NONSEQ;
        hsel   <= 1'b1;
        @(posedge hclk);
        htrans <= IDLE;
        hsel   <= 1'b0;
        @(negedge hclk);
        data = hrdata;                          // Mid data phase
        check_word(32'd1, 32'(hready));         // No wait states
    endtask

    task automatic wait_rx_data();
        logic [31:0]  rd;
        uart_status_t st;
        int           polls;
        polls = 0;
        ahb_read(`UART_REG_STATUS, rd);
        st = uart_status_t'(rd[4:0]);
        while (st.rx_empty) begin
            polls++;
            if (polls > 15 * cur_div) begin     // Each poll is two cycles
                abort_run($sformatf("Timeout in %s: receive FIFO stayed empty", test_name));
            end
            ahb_read(`UART_REG_STATUS, rd);
            st = uart_status_t'(rd[4:0]);
        end
    endtask

    task automatic recv_serial(output uart_byte_t data, output logic start_bit,
                               output logic stop_bit);
        int waited;
        waited = 0;
        @(negedge hclk);
        while (uart_tx) begin
            waited++;
            if (waited > 20 * cur_div) begin
                abort_run($sformatf("Timeout in %s: no start bit on uart_tx", test_name));
            end
            @(negedge hclk);
        end
        repeat (cur_div / 2) @(negedge hclk);   // Centre of start bit
        start_bit = uart_tx;
        for (int i = 0; i < 8; i++) begin
            repeat (cur_div) @(negedge hclk);
            data[i] = uart_tx;                  // LSB first
        end
        repeat (cur_div) @(negedge hclk);
        stop_bit = uart_tx;
    endtask

    task automatic send_serial(input uart_byte_t data, input logic stop_bit);
        @(posedge hclk);
        drv_line <= 1'b0;                       // Start bit
        repeat (cur_div) @(posedge hclk);
        for (int i = 0; i < 8; i++) begin
            drv_line <= data[i];
            repeat (cur_div) @(posedge hclk);
        end
        drv_line <= stop_bit;
        repeat (cur_div) @(posedge hclk);
        drv_line <= 1'b1;                       // One idle bit after the frame
        repeat (cur_div) @(posedge hclk);
    endtask

    task automatic test_reset();
        logic [31:0]  rd;
        uart_status_t exp;
        test_name = "reset_state";
        @(negedge hclk);
        check_word(32'd1, 32'(uart_tx));
        exp          = '0;
        exp.rx_empty = 1'b1;
        ahb_read(`UART_REG_STATUS, rd);
        check_status(exp, uart_status_t'(rd[4:0]));
        ahb_read(`UART_REG_BAUD, rd);
        check_word(32'(`UART_DIV_DEFAULT), rd);
    endtask

    task automatic test_baud();
        logic [31:0] rd;
        logic [31:0] div;
        test_name = "baud_register";
        div = 32'd8 + ($urandom % 33);          // 8 to 40 cycles per bit
        ahb_write(`UART_REG_BAUD, div);
        ahb_read(`UART_REG_BAUD, rd);
        check_word(div, rd);
        cur_div = div[`UART_DIV_WIDTH-1:0];
    endtask

    task automatic test_tx_frame();
        logic [31:0] rd;
        uart_byte_t  sent;
        uart_byte_t  got;
        logic        start_bit;
        logic        stop_bit;
        test_name = "transmit_frame";
        sent = uart_byte_t'($urandom);
        ahb_write(`UART_REG_TXDATA, 32'(sent));
        recv_serial(got, start_bit, stop_bit);
        check_word(32'd0, 32'(start_bit));
        check_byte(sent, got);
        check_word(32'd1, 32'(stop_bit));
        wait_rx_data();                         // Looped-back copy
        ahb_read(`UART_REG_RXDATA, rd);
        check_word({23'd0, 1'b0, sent}, rd);
    endtask

    task automatic test_loopback();
        logic [31:0] rd;
        uart_byte_t  sent [`UART_FIFO_DEPTH];
        test_name = "loopback_order";
        for (int i = 0; i < `UART_FIFO_DEPTH; i++) begin
            sent[i] = uart_byte_t'($urandom);
            ahb_write(`UART_REG_TXDATA, 32'(sent[i]));
        end
        for (int i = 0; i < `UART_FIFO_DEPTH; i++) begin
            wait_rx_data();
            ahb_read(`UART_REG_RXDATA, rd);
            check_word({23'd0, 1'b0, sent[i]}, rd);  // Frame error clear
        end
        ahb_read(`UART_REG_RXDATA, rd);
        check_word(32'd0, rd);                  // Empty FIFO reads zero
    endtask

    task automatic test_frame_error();
        logic [31:0]  rd;
        uart_byte_t   sent;
        uart_status_t exp;
        test_name = "frame_error";
        @(posedge hclk);
        use_driver <= 1'b1;
        sent = uart_byte_t'($urandom);
        send_serial(sent, 1'b0);                // Stop bit held low
        wait_rx_data();
        exp              = '0;
        exp.rx_frame_err = 1'b1;
        ahb_read(`UART_REG_STATUS, rd);
        check_status(exp, uart_status_t'(rd[4:0]));
        ahb_read(`UART_REG_RXDATA, rd);
        check_word({23'd0, 1'b1, sent}, rd);
        exp          = '0;
        exp.rx_empty = 1'b1;
        ahb_read(`UART_REG_STATUS, rd);
        check_status(exp, uart_status_t'(rd[4:0]));
    endtask

    task automatic test_overrun();
        logic [31:0]  rd;
        uart_byte_t   sent [`UART_FIFO_DEPTH + 1];
        uart_status_t exp;
        test_name = "overrun";
        for (int i = 0; i < `UART_FIFO_DEPTH + 1; i++) begin
            sent[i] = uart_byte_t'($urandom);
            send_serial(sent[i], 1'b1);         // Last one finds the FIFO full
        end
        exp         = '0;
        exp.overrun = 1'b1;
        ahb_read(`UART_REG_STATUS, rd);
        check_status(exp, uart_status_t'(rd[4:0]));
        for (int i = 0; i < `UART_FIFO_DEPTH; i++) begin
            ahb_read(`UART_REG_RXDATA, rd);
            check_word({23'd0, 1'b0, sent[i]}, rd);
        end
        ahb_write(`UART_REG_STATUS, $urandom);  // Any value clears overrun
        exp          = '0;
        exp.rx_empty = 1'b1;
        ahb_read(`UART_REG_STATUS, rd);
        check_status(exp, uart_status_t'(rd[4:0]));
    endtask

    initial begin
        void'($urandom(32'h3b20));
        reset      = 1'b1;
        haddr      = '0;
        hwdata     = '0;
        hwrite     = 1'b0;
        htrans     = IDLE;
        hsize      = 3'b010;                    // Word
        hburst     = 3'b000;                    // Single
        hsel       = 1'b0;
        use_driver = 1'b0;
        drv_line   = 1'b1;
        cur_div    = `UART_DIV_WIDTH'(`UART_DIV_DEFAULT);
        test_name  = "setup";
        repeat (2) @(posedge hclk);
        reset <= 1'b0;
        test_reset();
        test_baud();
        test_tx_frame();
        test_loopback();
        test_frame_error();
        test_overrun();
        repeat (4) @(posedge hclk);
        if (dut_i.props_i.assert_fails == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "Assertion failures during the run");
        end
    end

endmodule : ahb_uart_tb

// File: ahb_uart.f
+incdir+include
hw/ahb_pkg.sv
hw/uart_pkg.sv
hw/uart_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/ahb_uart_bridge.sv
hw/uart_regs.sv
hw/ahb_uart.sv
bench/ahb_uart_props.sv
bench/ahb_uart_tb.sv

// File: Bender.yml
package:
  name: ahb_uart

export_include_dirs:
  - include

sources:
  - files:
      - hw/ahb_pkg.sv
      - hw/uart_pkg.sv
      - hw/uart_fifo.sv
      - hw/uart_tx.sv
      - hw/uart_rx.sv
      - hw/ahb_uart_bridge.sv
      - hw/uart_regs.sv
      - hw/ahb_uart.sv
  - target: test
    files:
      - bench/ahb_uart_props.sv
      - bench/ahb_uart_tb.sv
